/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// ==============================
	// Field widths
	// ==============================
	localparam int WORD_W      = 32;
	localparam int REG_W       = 4;
	localparam int IMM12_W     = 12;
	localparam int SHIFT_IMM_W = 5;

	typedef logic [WORD_W-1:0]      word;
	typedef logic [REG_W-1:0]       reg_num;
	typedef logic [IMM12_W-1:0]     imm12;
	typedef logic [SHIFT_IMM_W-1:0] shift_amt;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	// ==============================
	// Encodings
	// ==============================
	typedef enum logic [3:0] {
		COND_EQ, COND_NE, COND_CS, COND_CC,
		COND_MI, COND_PL, COND_VS, COND_VC,
		COND_HI, COND_LS, COND_GE, COND_LT,
		COND_GT, COND_LE, COND_AL, COND_NV
	} cond_code;

	typedef enum logic [3:0] {
		ALU_AND, ALU_EOR, ALU_SUB, ALU_RSB,
		ALU_ADD, ALU_ADC, ALU_SBC, ALU_RSC,
		ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN,
		ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN
	} alu_op;

	typedef enum logic [1:0] {
		SHIFT_LSL, SHIFT_LSR, SHIFT_ASR, SHIFT_ROR
	} shift_kind;

	localparam reg_num R14 = 4'd14; // Link.
	localparam reg_num R15 = 4'd15; // Program counter.

endpackage

`default_nettype wire

/* uarch_pkg.sv */
`default_nettype none

package uarch_pkg;

	typedef struct packed {
		logic execute;
		logic undefined;
		logic branch;
		logic ldst;
		logic writeback;
		logic update_flags;
	} datapath_decode;

	typedef struct packed {
		isa_pkg::alu_op  op;
		isa_pkg::reg_num rd;
		isa_pkg::reg_num rn;
		logic            uses_rn;
	} data_decode;

	// Second operand, immediate or shifted register.
	typedef struct packed {
		logic               is_imm;
		isa_pkg::imm12      imm;  // Raw rotate/imm8 or ldst offset.
		isa_pkg::reg_num    r;
		isa_pkg::shift_kind shift;
		isa_pkg::shift_amt  shift_imm;
		logic               shift_by_reg;
		isa_pkg::reg_num    rs;
	} snd_decode;

	typedef struct packed {
		isa_pkg::word offset; // Byte offset, sign extended.
		logic         link;
	} branch_decode;

	typedef struct packed {
		logic load;
		logic is_byte;
		logic pre_index;
		logic up;
		logic writeback; // Base register update.
	} ldst_decode;

	typedef struct packed {
		datapath_decode ctrl;
		data_decode     data;
		snd_decode      snd;
		branch_decode   branch;
		ldst_decode     ldst;
	} decode_bundle;

endpackage

`default_nettype wire

/* core_insn_if.sv */
`default_nettype none

interface core_insn_if;

	logic              valid;
	logic              ready;
	isa_pkg::word      insn;
	isa_pkg::psr_flags flags;

	modport queue (
		output valid, insn, flags,
		input  ready
	);

	modport decoder (
		input  valid, insn, flags,
		output ready
	);

endinterface

`default_nettype wire

/* core_insn_queue.sv */
`default_nettype none

module core_insn_queue #(
	parameter int QUEUE_DEPTH = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  isa_pkg::word      in_insn,
	input  isa_pkg::psr_flags in_flags,
	output logic              in_ready,
	core_insn_if.queue        q
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	isa_pkg::word      insn_mem  [QUEUE_DEPTH];
	isa_pkg::psr_flags flags_mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W-1:0]  wr_ptr;
	logic [CNT_W-1:0]  count;
	logic              push;
	logic              pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign in_ready = count != CNT_W'(QUEUE_DEPTH);
	assign push     = in_valid && in_ready;
	assign pop      = q.valid && q.ready;

	assign q.valid = count != '0;  // Head entry.
	assign q.insn  = insn_mem[rd_ptr];
	assign q.flags = flags_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			insn_mem[wr_ptr]  <= in_insn;
			flags_mem[wr_ptr] <= in_flags;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* core_decode_conds.sv */
`default_nettype none

module core_decode_conds (
	input  isa_pkg::cond_code cond,
	input  isa_pkg::psr_flags flags,
	output logic              execute,
	output logic              undefined
);

	logic hit;

	// Odd codes are the inverse of the even code below them.
	always_comb begin
		hit       = 1'b0;
		undefined = 1'b0;

		unique case (cond)
			isa_pkg::COND_EQ, isa_pkg::COND_NE: hit = flags.z;
			isa_pkg::COND_CS, isa_pkg::COND_CC: hit = flags.c;
			isa_pkg::COND_MI, isa_pkg::COND_PL: hit = flags.n;
			isa_pkg::COND_VS, isa_pkg::COND_VC: hit = flags.v;
			isa_pkg::COND_HI, isa_pkg::COND_LS: hit = flags.c && !flags.z;
			isa_pkg::COND_GE, isa_pkg::COND_LT: hit = flags.n == flags.v;
			isa_pkg::COND_GT, isa_pkg::COND_LE: begin
				hit = (flags.n == flags.v) && !flags.z;
			end
			isa_pkg::COND_AL, isa_pkg::COND_NV: begin
				hit       = 1'b1;
				undefined = cond[0]; // NV.
			end
		endcase

		execute = hit ^ cond[0]; // NV never executes.
	end

endmodule

`default_nettype wire

/* core_decode_data.sv */
`default_nettype none

module core_decode_data (
	input  isa_pkg::word          insn,
	output uarch_pkg::data_decode data,
	output uarch_pkg::snd_decode  snd,
	output logic                  writeback,
	output logic                  update_flags
);

	isa_pkg::alu_op op;
	logic           s_bit;
	logic           is_test;

	assign op    = isa_pkg::alu_op'(insn[24:21]);
	assign s_bit = insn[20];

	assign is_test = op inside {isa_pkg::ALU_TST, isa_pkg::ALU_TEQ,
	                            isa_pkg::ALU_CMP, isa_pkg::ALU_CMN};

	// Compares only set flags.
	assign writeback    = !is_test;
	assign update_flags = s_bit || is_test;

	always_comb begin
		data.op      = op;
		data.rn      = insn[19:16];
		data.rd      = insn[15:12];
		data.uses_rn = !(op inside {isa_pkg::ALU_MOV, isa_pkg::ALU_MVN});
	end

	// ==============================
	// Second operand
	// ==============================
	always_comb begin
		snd.is_imm       = insn[25];
		snd.imm          = insn[11:0];  // Rotate and imm8, kept raw.
		snd.r            = insn[3:0];
		snd.shift        = isa_pkg::shift_kind'(insn[6:5]);
		snd.shift_imm    = insn[11:7];
		snd.shift_by_reg = !insn[25] && insn[4];
		snd.rs           = insn[11:8];
	end

endmodule

`default_nettype wire

/* core_decode.sv */
`default_nettype none

module core_decode (
	core_insn_if.decoder            dec,
	input  logic                    issue_ready,
	output logic                    dec_valid,
	output uarch_pkg::decode_bundle bundle
);

	isa_pkg::word          insn;
	logic                  cond_execute;
	logic                  cond_undefined;
	uarch_pkg::data_decode alu_data;
	uarch_pkg::snd_decode  alu_snd;
	logic                  alu_writeback;
	logic                  alu_update_flags;
	logic                  base_wb;

	assign insn      = dec.insn;
	assign dec_valid = dec.valid;
	assign dec.ready = issue_ready;

	assign base_wb = insn[21] || !insn[24]; // W set or post-index.

	core_decode_conds conds (
		.cond      (isa_pkg::cond_code'(insn[31:28])),
		.flags     (dec.flags),
		.execute   (cond_execute),
		.undefined (cond_undefined)
	);

	core_decode_data group_data (
		.insn         (insn),
		.data         (alu_data),
		.snd          (alu_snd),
		.writeback    (alu_writeback),
		.update_flags (alu_update_flags)
	);

	always_comb begin
		bundle                = '0;
		bundle.ctrl.execute   = cond_execute;
		bundle.ctrl.undefined = cond_undefined;

		unique casez (insn[27:25])
			// ==============================
			// Data processing
			// ==============================
			3'b00?: begin
				bundle.data              = alu_data;
				bundle.snd               = alu_snd;
				bundle.ctrl.writeback    = alu_writeback;
				bundle.ctrl.update_flags = alu_update_flags;
			end

			3'b101: begin
				bundle.ctrl.branch   = 1'b1;
				bundle.branch.link   = insn[24];
				bundle.branch.offset = {{6{insn[23]}}, insn[23:0], 2'b00};
				if (insn[24]) begin  // LR = PC - 4.
					bundle.data.op        = isa_pkg::ALU_SUB;
					bundle.data.rd        = isa_pkg::R14;
					bundle.data.rn        = isa_pkg::R15;
					bundle.data.uses_rn   = 1'b1;
					bundle.snd.is_imm     = 1'b1;
					bundle.snd.imm        = 12'd4;
					bundle.ctrl.writeback = 1'b1;
				end
			end

			// Single ldst, immediate offset.
			3'b010: begin
				bundle.ctrl.ldst      = 1'b1;
				bundle.ldst.pre_index = insn[24];
				bundle.ldst.up        = insn[23];
				bundle.ldst.is_byte   = insn[22];
				bundle.ldst.load      = insn[20];
				bundle.ldst.writeback = base_wb;
				bundle.data.op        = insn[23] ? isa_pkg::ALU_ADD : isa_pkg::ALU_SUB;
				bundle.data.rn        = insn[19:16];
				bundle.data.rd        = insn[15:12];
				bundle.data.uses_rn   = 1'b1;
				bundle.snd.is_imm     = 1'b1;
				bundle.snd.imm        = insn[11:0];
				bundle.ctrl.writeback = insn[20] || base_wb;
			end

			default: bundle.ctrl.undefined = 1'b1;
		endcase

		if (bundle.ctrl.undefined)
			bundle.ctrl.execute = 1'b0;
	end

endmodule

`default_nettype wire

/* core_decode_issue.sv */
`default_nettype none

module core_decode_issue (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    dec_valid,
	input  uarch_pkg::decode_bundle bundle_in,
	output logic                    load_en,
	output logic                    out_valid,
	input  logic                    out_ready,
	output uarch_pkg::decode_bundle bundle_out
);

	// Empty, or drained this cycle.
	assign load_en = out_ready || !out_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (load_en)
			out_valid <= dec_valid;
	end

	always_ff @(posedge clk) begin
		if (dec_valid && load_en)
			bundle_out <= bundle_in;
	end

endmodule

`default_nettype wire

/* core_decode_top.sv */
`default_nettype none

module core_decode_top #(
	parameter int QUEUE_DEPTH = 2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  isa_pkg::word       in_insn,
	input  isa_pkg::psr_flags  in_flags,
	output logic               in_ready,
	output logic               out_valid,
	input  logic               out_ready,
	output logic               execute,
	output logic               undefined,
	output logic               branch,
	output logic               ldst,
	output logic               writeback,
	output logic               update_flags,
	output isa_pkg::alu_op     alu_op,
	output isa_pkg::reg_num    rd,
	output isa_pkg::reg_num    rn,
	output logic               uses_rn,
	output logic               snd_is_imm,
	output isa_pkg::imm12      snd_imm,
	output isa_pkg::reg_num    snd_rm,
	output isa_pkg::shift_kind snd_shift,
	output isa_pkg::shift_amt  snd_shift_imm,
	output logic               snd_shift_by_reg,
	output isa_pkg::reg_num    snd_rs,
	output isa_pkg::word       branch_offset,
	output logic               branch_link,
	output logic               ld_load,
	output logic               ld_byte,
	output logic               ld_pre_index,
	output logic               ld_up,
	output logic               ld_writeback
);

	uarch_pkg::decode_bundle dec_bundle;
	uarch_pkg::decode_bundle issue_bundle;
	logic                    dec_valid;
	logic                    load_en;

	core_insn_if insn_link ();

	core_insn_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) queue (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_insn  (in_insn),
		.in_flags (in_flags),
		.in_ready (in_ready),
		.q        (insn_link.queue)
	);

	core_decode decode (
		.dec         (insn_link.decoder),
		.issue_ready (load_en),
		.dec_valid   (dec_valid),
		.bundle      (dec_bundle)
	);

	core_decode_issue issue (
		.clk        (clk),
		.rst_n      (rst_n),
		.dec_valid  (dec_valid),
		.bundle_in  (dec_bundle),
		.load_en    (load_en),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.bundle_out (issue_bundle)
	);

	// ==============================
	// Flattened issue fields
	// ==============================
	assign execute      = issue_bundle.ctrl.execute;
	assign undefined    = issue_bundle.ctrl.undefined;
	assign branch       = issue_bundle.ctrl.branch;
	assign ldst         = issue_bundle.ctrl.ldst;
	assign writeback    = issue_bundle.ctrl.writeback;
	assign update_flags = issue_bundle.ctrl.update_flags;

	assign alu_op  = issue_bundle.data.op;
	assign rd      = issue_bundle.data.rd;
	assign rn      = issue_bundle.data.rn;
	assign uses_rn = issue_bundle.data.uses_rn;

	assign snd_is_imm       = issue_bundle.snd.is_imm;
	assign snd_imm          = issue_bundle.snd.imm;
	assign snd_rm           = issue_bundle.snd.r;
	assign snd_shift        = issue_bundle.snd.shift;
	assign snd_shift_imm    = issue_bundle.snd.shift_imm;
	assign snd_shift_by_reg = issue_bundle.snd.shift_by_reg;
	assign snd_rs           = issue_bundle.snd.rs;

	assign branch_offset = issue_bundle.branch.offset;
	assign branch_link   = issue_bundle.branch.link;

	assign ld_load      = issue_bundle.ldst.load;
	assign ld_byte      = issue_bundle.ldst.is_byte;
	assign ld_pre_index = issue_bundle.ldst.pre_index;
	assign ld_up        = issue_bundle.ldst.up;
	assign ld_writeback = issue_bundle.ldst.writeback;

endmodule

`default_nettype wire

/* core_decode_tb.sv */
`default_nettype none

module core_decode_tb;

	localparam int N_COND   = 256;
	localparam int N_DATA   = 200;
	localparam int N_BRANCH = 100;
	localparam int N_LDST   = 150;
	localparam int N_BP     = 103;
	localparam int N_TOTAL  = N_COND + N_DATA + N_BRANCH + N_LDST + N_BP;
	localparam int CYCLE_LIMIT = 4 * N_TOTAL + 200;

	localparam logic [1:0] KIND_DATA   = 2'd0;
	localparam logic [1:0] KIND_BRANCH = 2'd1;
	localparam logic [1:0] KIND_LDST   = 2'd2;
	localparam logic [1:0] KIND_UNDEF  = 2'd3;

	typedef struct packed {
		logic execute, undefined, branch, ldst, writeback, update_flags;
		logic [3:0] op, rd, rn;
		logic uses_rn, is_imm;
		logic [11:0] imm;
		logic [3:0] rm;
		logic [1:0] shift;
		logic [4:0] shift_imm;
		logic by_reg;
		logic [3:0] rs;
		logic [31:0] offset;
		logic link, load, is_byte, pre_index, up, base_wb;
		logic [1:0] kind;
	} expect_t;

	logic clk, rst_n, in_valid, in_ready, out_valid, out_ready;
	logic [31:0] in_insn;
	isa_pkg::psr_flags in_flags;
	logic execute, undefined, branch, ldst, writeback, update_flags;
	isa_pkg::alu_op alu_op;
	logic [3:0] rd, rn, snd_rm, snd_rs;
	logic uses_rn, snd_is_imm, snd_shift_by_reg;
	logic [11:0] snd_imm;
	isa_pkg::shift_kind snd_shift;
	logic [4:0] snd_shift_imm;
	logic [31:0] branch_offset;
	logic branch_link, ld_load, ld_byte, ld_pre_index, ld_up, ld_writeback;

	logic [85:0] out_fields;
	logic [85:0] held_fields;
	logic        stalled;
	logic [35:0] sb_q[$];    // {insn, flags} in issue order.
	logic [35:0] entry;
	logic [31:0] r, r2;
	logic [2:0]  grp;
	logic        bp_random;
	int          seed = 32'h4afa_c244;
	int          errors = 0;
	int          checks = 0;
	int          err_start;
	int          cycles;

	core_decode_top #(.QUEUE_DEPTH(2)) UUT (.*);

	assign out_fields = {execute, undefined, branch, ldst, writeback, update_flags,
		alu_op, rd, rn, uses_rn, snd_is_imm, snd_imm, snd_rm, snd_shift, snd_shift_imm,
		snd_shift_by_reg, snd_rs, branch_offset, branch_link,
		ld_load, ld_byte, ld_pre_index, ld_up, ld_writeback};

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==============================
	// Reference model
	// ==============================
	function automatic expect_t ref_decode(input logic [31:0] insn, input logic [3:0] flags);
		expect_t e;
		logic n, z, c, v, hit;
		e = '0;
		{n, z, c, v} = flags;
		case (insn[31:28])
			4'h0: hit = z;
			4'h1: hit = !z;
			4'h2: hit = c;
			4'h3: hit = !c;
			4'h4: hit = n;
			4'h5: hit = !n;
			4'h6: hit = v;
			4'h7: hit = !v;
			4'h8: hit = c && !z;
			4'h9: hit = !c || z;
			4'ha: hit = n == v;
			4'hb: hit = n != v;
			4'hc: hit = !z && (n == v);
			4'hd: hit = z || (n != v);
			4'he: hit = 1'b1;
			default: hit = 1'b0;
		endcase
		e.undefined = insn[31:28] == 4'hf;
		case (insn[27:25])
			3'b000, 3'b001: begin
				e.kind = KIND_DATA;
				e.op = insn[24:21];
				e.rn = insn[19:16];
				e.rd = insn[15:12];
				e.writeback = e.op[3:2] != 2'b10;          // TST..CMN write nothing.
				e.update_flags = insn[20] || e.op[3:2] == 2'b10;
				e.uses_rn = !(e.op == 4'hd || e.op == 4'hf);
				e.is_imm = insn[25];
				e.imm = insn[11:0];
				e.rm = insn[3:0];
				e.shift = insn[6:5];
				e.by_reg = insn[4];    // Register form only.
				e.shift_imm = insn[11:7];
				e.rs = insn[11:8];
			end
			3'b101: begin
				e.kind = KIND_BRANCH;
				e.branch = 1'b1;
				e.link = insn[24];
				e.offset = {{8{insn[23]}}, insn[23:0]} << 2;
				if (e.link) begin
					e.op = 4'h2;
					e.rd = 4'd14;
					e.rn = 4'd15;
					e.uses_rn = 1'b1;
					e.is_imm = 1'b1;
					e.imm = 12'd4;
					e.writeback = 1'b1;
				end
			end
			3'b010: begin
				e.kind = KIND_LDST;
				e.ldst = 1'b1;
				e.pre_index = insn[24];
				e.up = insn[23];
				e.is_byte = insn[22];
				e.load = insn[20];
				e.base_wb = insn[21] || !insn[24];
				e.op = insn[23] ? 4'h4 : 4'h2;
				e.rn = insn[19:16];
				e.rd = insn[15:12];
				e.uses_rn = 1'b1;
				e.is_imm = 1'b1;
				e.imm = insn[11:0];
				e.writeback = e.load || e.base_wb;
			end
			default: begin
				e.kind = KIND_UNDEF;
				e.undefined = 1'b1;
			end
		endcase
		e.execute = e.undefined ? 1'b0 : hit;
		return e;
	endfunction

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_outputs(input logic [31:0] insn, input logic [3:0] flags);
		expect_t e;
		e = ref_decode(insn, flags);
		check_field("execute", 32'(execute), 32'(e.execute));
		check_field("undefined", 32'(undefined), 32'(e.undefined));
		check_field("branch", 32'(branch), 32'(e.branch));
		check_field("ldst", 32'(ldst), 32'(e.ldst));
		case (e.kind)
			KIND_DATA: begin
				check_field("writeback", 32'(writeback), 32'(e.writeback));
				check_field("update_flags", 32'(update_flags), 32'(e.update_flags));
				check_field("alu_op", 32'(alu_op), 32'(e.op));
				check_field("rd", 32'(rd), 32'(e.rd));
				check_field("rn", 32'(rn), 32'(e.rn));
				check_field("uses_rn", 32'(uses_rn), 32'(e.uses_rn));
				check_field("snd_is_imm", 32'(snd_is_imm), 32'(e.is_imm));
				if (e.is_imm) begin
					check_field("snd_imm", 32'(snd_imm), 32'(e.imm));
				end else begin
					check_field("snd_rm", 32'(snd_rm), 32'(e.rm));
					check_field("snd_shift", 32'(snd_shift), 32'(e.shift));
					check_field("snd_shift_by_reg", 32'(snd_shift_by_reg), 32'(e.by_reg));
					if (e.by_reg)
						check_field("snd_rs", 32'(snd_rs), 32'(e.rs));
					else
						check_field("snd_shift_imm", 32'(snd_shift_imm), 32'(e.shift_imm));
				end
			end
			KIND_BRANCH: begin
				check_field("branch_offset", branch_offset, e.offset);
				check_field("branch_link", 32'(branch_link), 32'(e.link));
				if (e.link) begin    // LR = PC - 4.
					check_field("alu_op", 32'(alu_op), 32'(e.op));
					check_field("rd", 32'(rd), 32'(e.rd));
					check_field("rn", 32'(rn), 32'(e.rn));
					check_field("uses_rn", 32'(uses_rn), 32'(e.uses_rn));
					check_field("snd_is_imm", 32'(snd_is_imm), 32'(e.is_imm));
					check_field("snd_imm", 32'(snd_imm), 32'(e.imm));
					check_field("writeback", 32'(writeback), 32'(e.writeback));
				end
			end
			KIND_LDST: begin
				check_field("ld_load", 32'(ld_load), 32'(e.load));
				check_field("ld_byte", 32'(ld_byte), 32'(e.is_byte));
				check_field("ld_pre_index", 32'(ld_pre_index), 32'(e.pre_index));
				check_field("ld_up", 32'(ld_up), 32'(e.up));
				check_field("ld_writeback", 32'(ld_writeback), 32'(e.base_wb));
				check_field("alu_op", 32'(alu_op), 32'(e.op));
				check_field("rn", 32'(rn), 32'(e.rn));
				check_field("rd", 32'(rd), 32'(e.rd));
				check_field("uses_rn", 32'(uses_rn), 32'(e.uses_rn));
				check_field("snd_is_imm", 32'(snd_is_imm), 32'(e.is_imm));
				check_field("snd_imm", 32'(snd_imm), 32'(e.imm));
				check_field("writeback", 32'(writeback), 32'(e.writeback));
			end
			default: ;
		endcase
	endtask

	// ==============================
	// Output monitor
	// ==============================
	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			checks++;
			assert (sb_q.size() != 0) else begin
				$display("Output transfer seen with no instruction outstanding");
				errors++;
			end
			if (sb_q.size() != 0) begin
				entry = sb_q.pop_front();
				compare_outputs(entry[35:4], entry[3:0]);
			end
		end
		if (stalled) begin    // Must hold while stalled.
			check_field("out_valid", 32'(out_valid), 32'd1);
			checks++;
			assert (out_fields === held_fields) else begin
				$display("Fail out_fields: got %h, expected %h", out_fields, held_fields);
				errors++;
			end
		end
		stalled = rst_n && out_valid && !out_ready;
		held_fields = out_fields;
	end

	// ==============================
	// Stimulus helpers
	// ==============================
	task automatic tick();
		@(negedge clk);
		if (bp_random) begin
			r2 = $random(seed);
			out_ready = r2[0];
		end
	endtask

	// Called at a falling edge and returns one edge after the transfer.
	task automatic send(input logic [31:0] insn, input logic [3:0] flags);
		in_valid = 1'b1;
		in_insn = insn;
		in_flags = flags;
		while (!in_ready)
			tick();
		sb_q.push_back({insn, flags});
		tick();
	endtask

	task automatic wait_drain();
		in_valid = 1'b0;
		while (sb_q.size() != 0)
			tick();
	endtask

	task automatic report_test(input string name, input int count);
		$display("Test %s: %0d instructions, %0d errors", name, count, errors - err_start);
		err_start = errors;
	endtask

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Done: errors found");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_insn = '0;
		in_flags = '0;
		out_ready = 1'b1;
		bp_random = 1'b0;
		stalled = 1'b0;
		err_start = 0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_field("out_valid", 32'(out_valid), 32'd0);
		check_field("in_ready", 32'(in_ready), 32'd1);

		for (int i = 0; i < 16; i++) begin
			for (int j = 0; j < 16; j++) begin
				r = $random(seed);
				send({i[3:0], 2'b00, r[25:0]}, j[3:0]);
			end
		end
		wait_drain();
		report_test("conditions", N_COND);

		for (int i = 0; i < N_DATA; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			send({r[31:28], 2'b00, r[25:0]}, r2[3:0]);
		end
		wait_drain();
		report_test("data processing", N_DATA);

		for (int i = 0; i < N_BRANCH; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			send({r[31:28], 3'b101, r[24:0]}, r2[3:0]);
		end
		wait_drain();
		report_test("branches", N_BRANCH);

		// Last fifth uses groups that are not supported.
		for (int i = 0; i < N_LDST; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			case (r2[5:4])
				2'd0: grp = 3'b011;
				2'd1: grp = 3'b100;
				2'd2: grp = 3'b110;
				default: grp = 3'b111;
			endcase
			if (i < 120)
				grp = 3'b010;
			send({r[31:28], grp, r[24:0]}, r2[3:0]);
		end
		wait_drain();
		report_test("load/store", N_LDST);

		// Fill the queue behind a stalled issue register.
		out_ready = 1'b0;
		@(negedge clk);
		for (int i = 0; i < 3; i++) begin
			r = $random(seed);
			send({4'he, 3'b010, r[24:0]}, 4'h0);
		end
		in_valid = 1'b0;
		check_field("in_ready", 32'(in_ready), 32'd0);
		repeat (4) tick();
		out_ready = 1'b1;
		bp_random = 1'b1;
		for (int i = 0; i < N_BP - 3; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			send(r, r2[3:0]);
		end
		wait_drain();
		bp_random = 1'b0;
		out_ready = 1'b1;
		repeat (4) tick();
		report_test("back-pressure", N_BP);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
isa_pkg.sv
uarch_pkg.sv
core_insn_if.sv
core_insn_queue.sv
core_decode_conds.sv
core_decode_data.sv
core_decode.sv
core_decode_issue.sv
core_decode_top.sv
core_decode_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.

LOG=sim.log

verilator --binary --assert -f compile.f --top-module core_decode_tb -o core_decode_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/core_decode_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
	exit 1
fi
exit 0
